// ==== common/dsp_seq_pkg.sv ====
`default_nettype none

package dsp_seq_pkg;

	// one adc sample, also one dac lane
	localparam int SAMPLE_W = 16;
	// lanes packed in one dac word
	localparam int DAC_LANES = 16;
	// keep every fourth dac lane
	localparam int US_RATIO = 4;
	// lanes left after undersampling
	localparam int US_LANES = 4;

	typedef logic [SAMPLE_W-1:0] sample_t;

	// full dac word as it leaves the element outputs
	typedef logic [DAC_LANES*SAMPLE_W-1:0] dac_word_t;

	// mixer input word
	// adc samples are zero-extended into it
	typedef logic [US_LANES*SAMPLE_W-1:0] bb_word_t;

	// accumulator result, x upper half and y lower half
	typedef logic [63:0] acc_data_t;

	// shot numbers and shot counts
	typedef logic [31:0] shot_cnt_t;

	// mixer source select
	// 0 adc, 1 and 2 undersampled dac, 3 hold
	typedef logic [1:0] bb_sel_t;

	// shot sequencer states
	// neighbouring states differ in one bit
	typedef enum logic [2:0] {
		st_idle      = 3'b000,
		st_start     = 3'b001,
		st_proc_run  = 3'b011,
		st_elem_busy = 3'b010,
		st_more_shot = 3'b110,
		st_shot_add  = 3'b111,
		st_done      = 3'b101
	} seq_state_t;

endpackage

`default_nettype wire

// ==== design/accbuf_writer.sv ====
`default_nettype none

module accbuf_writer #(
	parameter int NDLO = 4,
	parameter int ACC_ADDR_W = 4
) (
	input wire dspif,
	input wire rst_n,
	input wire [NDLO-1:0] acc_valid,
	input wire dsp_seq_pkg::acc_data_t acc_data [NDLO],
	input wire acc_reset,
	output logic [NDLO-1:0] acc_we,
	output logic [ACC_ADDR_W-1:0] acc_addr [NDLO],
	output dsp_seq_pkg::acc_data_t acc_wdata [NDLO]
);

	// accumulator reset, one stage, shared by all channels
	logic acc_reset_r;
	// address parked at the top of the buffer
	logic [NDLO-1:0] addr_last;

	always_comb begin
		for (int i = 0; i < NDLO; i++) begin
			addr_last[i] = &acc_addr[i];
		end
	end

	// strobe and reset, one cycle
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			acc_reset_r <= 1'b0;
			acc_we      <= '0;
		end else begin
			acc_reset_r <= acc_reset;
			acc_we      <= acc_valid;
		end
	end

	// data rides along with acc_we
	always_ff @(posedge dspif) begin
		acc_wdata <= acc_data;
	end

	// step after every write, stop at all ones
	// later writes land on the last word
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < NDLO; i++) begin
				acc_addr[i] <= '0;
			end
		end else begin
			for (int i = 0; i < NDLO; i++) begin
				if (acc_reset_r) begin
					acc_addr[i] <= '0;
				end else if (acc_we[i] && !addr_last[i]) begin
					acc_addr[i] <= acc_addr[i] + 1'b1;
				end
			end
		end
	end

	for (genvar ch = 0; ch < NDLO; ch++) begin : g_lock_chk
		a_addr_lock: assert property (@(posedge dspif) disable iff (!rst_n)
			(addr_last[ch] && !acc_reset_r) |=> (acc_addr[ch] != '0))
			else $error("accumulation address wrapped without reset");
	end

endmodule

`default_nettype wire

// ==== design/baseband_select.sv ====
`default_nettype none

module baseband_select (
	input wire dspif,
	input wire rst_n,
	input wire dsp_seq_pkg::sample_t adc [2],
	input wire dsp_seq_pkg::dac_word_t dac [4],
	input wire dsp_seq_pkg::bb_sel_t bb1_sel,
	input wire dsp_seq_pkg::bb_sel_t bb2_sel,
	output dsp_seq_pkg::bb_word_t bb1,
	output dsp_seq_pkg::bb_word_t bb2
);
	import dsp_seq_pkg::*;

	// first stage, adc as received
	sample_t adc_r [2];
	// first stage, every US_RATIO-th dac lane
	bb_word_t dac_us [4];

	// pick one mixer source
	// anything past 2 keeps the last word
	function automatic bb_word_t pick_src(
		input bb_sel_t sel,
		input bb_word_t held,
		input bb_word_t src0,
		input bb_word_t src1,
		input bb_word_t src2
	);
		case (sel)
			2'd0: return src0;
			2'd1: return src1;
			2'd2: return src2;
			default: return held;
		endcase
	endfunction

	// data path registers
	always_ff @(posedge dspif) begin
		adc_r <= adc;
		for (int i = 0; i < $size(dac); i++) begin
			for (int j = 0; j < US_LANES; j++) begin
				// lane j from dac lane US_RATIO*j
				dac_us[i][j*SAMPLE_W +: SAMPLE_W] <= dac[i][j*US_RATIO*SAMPLE_W +: SAMPLE_W];
			end
		end
	end

	// second stage, registered mux per mixer path
	// bb1 sees adc 0 or dac 0/1, bb2 sees adc 1 or dac 2/3
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			bb1 <= '0;
			bb2 <= '0;
		end else begin
			bb1 <= pick_src(bb1_sel, bb1, bb_word_t'(adc_r[0]), dac_us[0], dac_us[1]);
			bb2 <= pick_src(bb2_sel, bb2, bb_word_t'(adc_r[1]), dac_us[2], dac_us[3]);
		end
	end

endmodule

`default_nettype wire

// ==== design/dsp_core.sv ====
`default_nettype none

module dsp_core #(
	// processor cores on the handshake
	parameter int NPROC = 4,
	// demodulation channels with a buffer each
	parameter int NDLO = 4,
	parameter int ACC_ADDR_W = 4
) (
	input wire dspif,
	input wire rst_n,

	// host shot control
	input wire start,
	input wire dsp_seq_pkg::shot_cnt_t nshot,
	output logic last_shot_done,
	output dsp_seq_pkg::shot_cnt_t shot_cnt,

	// core handshake
	output logic [NPROC-1:0] proc_reset,
	input wire [NPROC-1:0] proc_done,
	input wire [NPROC-1:0] elem_idle,

	// converter data and mixer inputs
	input wire dsp_seq_pkg::sample_t adc [2],
	input wire dsp_seq_pkg::dac_word_t dac [4],
	input wire dsp_seq_pkg::bb_sel_t bb1_sel,
	input wire dsp_seq_pkg::bb_sel_t bb2_sel,
	output dsp_seq_pkg::bb_word_t bb1,
	output dsp_seq_pkg::bb_word_t bb2,

	// accumulator results and buffer write side
	input wire [NDLO-1:0] acc_valid,
	input wire dsp_seq_pkg::acc_data_t acc_data [NDLO],
	input wire acc_reset,
	output logic [NDLO-1:0] acc_we,
	output logic [ACC_ADDR_W-1:0] acc_addr [NDLO],
	output dsp_seq_pkg::acc_data_t acc_wdata [NDLO]
);

	// shot loop over all cores
	shot_sequencer #(
		.NPROC (NPROC)
	) shot_sequencer_i (
		.dspif          (dspif),
		.rst_n          (rst_n),
		.start          (start),
		.nshot          (nshot),
		.proc_done      (proc_done),
		.elem_idle      (elem_idle),
		.proc_reset     (proc_reset),
		.last_shot_done (last_shot_done),
		.shot_cnt       (shot_cnt)
	);

	// mixer sources, 2 cycles from converter to bb
	baseband_select baseband_select_i (
		.dspif   (dspif),
		.rst_n   (rst_n),
		.adc     (adc),
		.dac     (dac),
		.bb1_sel (bb1_sel),
		.bb2_sel (bb2_sel),
		.bb1     (bb1),
		.bb2     (bb2)
	);

	// one write port per demodulation channel
	accbuf_writer #(
		.NDLO       (NDLO),
		.ACC_ADDR_W (ACC_ADDR_W)
	) accbuf_writer_i (
		.dspif     (dspif),
		.rst_n     (rst_n),
		.acc_valid (acc_valid),
		.acc_data  (acc_data),
		.acc_reset (acc_reset),
		.acc_we    (acc_we),
		.acc_addr  (acc_addr),
		.acc_wdata (acc_wdata)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the dsp_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f src.f --top-module tb_dsp_core -o sim_tb_dsp_core

out=$(./obj_dir/sim_tb_dsp_core)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

// ==== sequencer/shot_counter.sv ====
`default_nettype none

module shot_counter (
	input wire dspif,
	input wire rst_n,
	input wire load,
	input wire clear,
	input wire count,
	input wire dsp_seq_pkg::shot_cnt_t nshot,
	output logic another_shot,
	output dsp_seq_pkg::shot_cnt_t shot_cnt
);
	import dsp_seq_pkg::*;

	// shot number held for the whole run
	shot_cnt_t nshot_r;
	// completed shots of the current run
	shot_cnt_t run_cnt;
	// run_cnt plus one, one cycle behind
	shot_cnt_t next_cnt;

	// nshot only follows the input while the sequencer idles
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			nshot_r <= '0;
		end else if (load) begin
			nshot_r <= nshot;
		end
	end

	// clear on a new start, count once per finished shot
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			run_cnt <= '0;
		end else if (clear) begin
			run_cnt <= '0;
		end else if (count) begin
			run_cnt <= run_cnt + 1'b1;
		end
	end

	// two stage compare, settled long before more_shot reads it
	// nshot_r of zero never ends the run
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			next_cnt     <= '0;
			another_shot <= 1'b0;
		end else begin
			next_cnt     <= run_cnt + 1'b1;
			another_shot <= (next_cnt != nshot_r) || (nshot_r == '0);
		end
	end

	// completed shots go straight out
	assign shot_cnt = run_cnt;

	// clear comes from idle and count from more_shot
	a_count_clear: assert property (@(posedge dspif) disable iff (!rst_n)
		!(count && clear))
		else $error("shot counter cleared and counted in one cycle");

endmodule

`default_nettype wire

// ==== sequencer/shot_sequencer.sv ====
`default_nettype none

module shot_sequencer #(
	parameter int NPROC = 4
) (
	input wire dspif,
	input wire rst_n,
	input wire start,
	input wire dsp_seq_pkg::shot_cnt_t nshot,
	input wire [NPROC-1:0] proc_done,
	input wire [NPROC-1:0] elem_idle,
	output logic [NPROC-1:0] proc_reset,
	output logic last_shot_done,
	output dsp_seq_pkg::shot_cnt_t shot_cnt
);
	import dsp_seq_pkg::*;

	seq_state_t state;
	seq_state_t next_state;

	// every core finished its program
	logic all_done_r;
	// every core has its elements stopped
	logic all_idle_r;
	logic another_shot;
	logic cnt_load;
	logic cnt_clear;
	logic cnt_count;

	// handshake levels, one register stage
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			all_done_r <= 1'b0;
			all_idle_r <= 1'b0;
		end else begin
			all_done_r <= &proc_done;
			all_idle_r <= &elem_idle;
		end
	end

	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = st_idle;
		case (state)
			st_idle: next_state = start ? st_start : st_idle;
			// cores leave reset here
			st_start: next_state = st_proc_run;
			// variable latency until the last core reports done
			st_proc_run: next_state = all_done_r ? st_elem_busy : st_proc_run;
			st_elem_busy: next_state = all_idle_r ? st_more_shot : st_elem_busy;
			st_more_shot: next_state = another_shot ? st_shot_add : st_done;
			st_shot_add: next_state = st_start;
			st_done: next_state = st_idle;
			default: next_state = st_idle;
		endcase
	end

	// outputs come from next_state so they line up with the state
	// cores run only in start and proc_run
	always_ff @(posedge dspif or negedge rst_n) begin
		if (!rst_n) begin
			proc_reset     <= '1;
			last_shot_done <= 1'b0;
		end else begin
			proc_reset     <= {NPROC{!(next_state inside {st_start, st_proc_run})}};
			last_shot_done <= (next_state == st_done);
		end
	end

	// nshot tracks the host while idle
	assign cnt_load  = (state == st_idle);
	// a new run starts from zero
	assign cnt_clear = (state == st_idle) && start;
	// shot counted on the way out of more_shot
	// so shot_cnt already equals nshot during done
	assign cnt_count = (state == st_more_shot);

	shot_counter shot_counter_i (
		.dspif        (dspif),
		.rst_n        (rst_n),
		.load         (cnt_load),
		.clear        (cnt_clear),
		.count        (cnt_count),
		.nshot        (nshot),
		.another_shot (another_shot),
		.shot_cnt     (shot_cnt)
	);

	a_reset_window: assert property (@(posedge dspif) disable iff (!rst_n)
		(proc_reset != '1) |-> (state inside {st_start, st_proc_run}))
		else $error("cores out of reset outside start and proc_run");

	a_done_pulse: assert property (@(posedge dspif) disable iff (!rst_n)
		last_shot_done |=> !last_shot_done)
		else $error("last_shot_done held for two cycles");

endmodule

`default_nettype wire

// ==== src.f ====
common/dsp_seq_pkg.sv
sequencer/shot_counter.sv
sequencer/shot_sequencer.sv
design/baseband_select.sv
design/accbuf_writer.sv
design/dsp_core.sv
testbench/tb_dsp_core.sv

// ==== testbench/tb_dsp_core.sv ====
`default_nettype none

module tb_dsp_core;
	timeunit 1ns;
	timeprecision 100ps;
	import dsp_seq_pkg::*;

	localparam int NPROC = 4;
	localparam int NDLO = 4;
	localparam int ACC_ADDR_W = 4;

	logic dspif = 1'b0;
	logic rst_n;
	logic start;
	shot_cnt_t nshot;
	logic [NPROC-1:0] proc_done;
	logic [NPROC-1:0] elem_idle;
	sample_t adc [2];
	dac_word_t dac [4];
	bb_sel_t bb1_sel;
	bb_sel_t bb2_sel;
	logic [NDLO-1:0] acc_valid;
	acc_data_t acc_data [NDLO];
	logic acc_reset;
	logic [NPROC-1:0] proc_reset;
	logic last_shot_done;
	shot_cnt_t shot_cnt;
	bb_word_t bb1;
	bb_word_t bb2;
	logic [NDLO-1:0] acc_we;
	logic [ACC_ADDR_W-1:0] acc_addr [NDLO];
	acc_data_t acc_wdata [NDLO];

	// stimulus and core model random streams
	logic [15:0] lfsr = 16'd35;
	logic [15:0] core_lfsr = 16'd35;
	int errors = 0;
	int pass_cnt = 0;
	int fail_cnt = 0;
	// sequencer observations from the checker
	int fall_cnt = 0;
	int pulse_cnt = 0;
	shot_cnt_t cnt_steps [$];
	int core_dly [NPROC];
	logic pr_seen_core = 1'b1;

	dsp_core #(.NPROC(NPROC), .NDLO(NDLO), .ACC_ADDR_W(ACC_ADDR_W)) dsp_core_i (.*);

	always #10 dspif = ~dspif;

	// taps 16 14 13 11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// n fresh bits, one lfsr step each
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// 1 to 15 cycles for a core response
	function automatic int core_delay();
		logic [3:0] r;
		r = '0;
		for (int i = 0; i < 4; i++) begin
			core_lfsr = lfsr_next(core_lfsr);
			r = {r[2:0], core_lfsr[0]};
		end
		return 1 + (r % 15);
	endfunction

	// lane j is dac lane 4*j
	function automatic bb_word_t us_word(input dac_word_t w);
		bb_word_t r;
		for (int j = 0; j < US_LANES; j++) begin
			r[j*SAMPLE_W +: SAMPLE_W] = w[j*US_RATIO*SAMPLE_W +: SAMPLE_W];
		end
		return r;
	endfunction

	function automatic bb_word_t ref_mux(input bb_sel_t sel, input bb_word_t held,
			input sample_t a, input dac_word_t d0, input dac_word_t d1);
		case (sel)
			2'd0: return bb_word_t'(a);
			2'd1: return us_word(d0);
			2'd2: return us_word(d1);
			default: return held;
		endcase
	endfunction

	// locking address step
	function automatic logic [ACC_ADDR_W-1:0] ref_addr(input logic [ACC_ADDR_W-1:0] a,
			input logic clr, input logic we);
		if (clr) return '0;
		if (we && a != '1) return a + 1'b1;
		return a;
	endfunction

	task automatic expect_eq(input string what, input logic [255:0] got,
			input logic [255:0] exp);
		assert (got === exp)
		else begin
			$display("FAIL %0t: %s is %h, expected %h", $time, what, got, exp);
			errors++;
		end
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt + 1);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic end_test(input string name, input int err_before);
		if (errors == err_before) begin
			pass_cnt++;
			$display("test %s: ok", name);
		end else begin
			fail_cnt++;
			$display("test %s: %0d errors", name, errors - err_before);
		end
	endtask

	task automatic next_drive();
		@(posedge dspif);
		#2;
	endtask

	task automatic run_cycles(input int n);
		for (int i = 0; i < n; i++) begin
			next_drive();
		end
	endtask

	task automatic wait_last_shot(input int limit);
		int n;
		n = 0;
		while (last_shot_done !== 1'b1) begin
			@(negedge dspif);
			n++;
			if (n > limit) abort_run("timeout: last_shot_done never came");
		end
	endtask

	task automatic wait_shots_above(input int cnt, input int limit);
		int n;
		n = 0;
		while (shot_cnt <= cnt) begin
			@(negedge dspif);
			n++;
			if (n > limit) abort_run("timeout: shot count stopped rising");
		end
	endtask

	task automatic pulse_start(input shot_cnt_t n);
		nshot = n;
		start = 1'b1;
		next_drive();
		start = 1'b0;
	endtask

	// core model, done after reset falls, idle after it rises
	always @(posedge dspif) begin
		#2;
		for (int c = 0; c < NPROC; c++) begin
			if (!proc_reset[c] && pr_seen_core) begin
				core_dly[c] = core_delay();
				proc_done[c] = 1'b0;
				elem_idle[c] = 1'b0;
			end else if (proc_reset[c] && !pr_seen_core) begin
				core_dly[c] = core_delay();
				proc_done[c] = 1'b0;
			end else if (core_dly[c] > 0) begin
				core_dly[c]--;
			end else if (!proc_reset[c]) begin
				proc_done[c] = 1'b1;
			end else begin
				elem_idle[c] = 1'b1;
			end
		end
		pr_seen_core = proc_reset[0];
	end

	// checker, samples at the falling edge where all is stable
	sample_t adc_h [2];
	dac_word_t dac_h [4];
	bb_sel_t sel1_h, sel2_h;
	logic [NDLO-1:0] valid_h;
	acc_data_t data_h [NDLO];
	logic accrst_h, rst_h;
	sample_t adc_m [2];
	dac_word_t dac_m [4];
	bb_word_t bb1_m, bb2_m;
	logic [NDLO-1:0] we_m;
	logic clr_m;
	logic [ACC_ADDR_W-1:0] addr_m [NDLO];
	acc_data_t wdata_m [NDLO];
	logic pr_prev = 1'b1, lsd_prev = 1'b0, done_seen = 1'b0, idle_seen = 1'b1;
	shot_cnt_t cnt_prev = '0;
	int ticks = 0;

	always @(negedge dspif) begin
		// model registers step with the edge just passed
		if (!rst_n || !rst_h) begin
			bb1_m = '0;
			bb2_m = '0;
			we_m = '0;
			clr_m = 1'b0;
			for (int i = 0; i < NDLO; i++) addr_m[i] = '0;
		end else begin
			bb1_m = ref_mux(sel1_h, bb1_m, adc_m[0], dac_m[0], dac_m[1]);
			bb2_m = ref_mux(sel2_h, bb2_m, adc_m[1], dac_m[2], dac_m[3]);
			for (int i = 0; i < NDLO; i++) addr_m[i] = ref_addr(addr_m[i], clr_m, we_m[i]);
			we_m = valid_h;
			clr_m = accrst_h;
		end
		adc_m = adc_h;
		dac_m = dac_h;
		wdata_m = data_h;
		ticks++;
		if (ticks > 2) begin
			expect_eq("bb1", bb1, bb1_m);
			expect_eq("bb2", bb2, bb2_m);
			expect_eq("acc_we", acc_we, we_m);
			for (int i = 0; i < NDLO; i++) begin
				expect_eq("acc_addr", acc_addr[i], addr_m[i]);
				if (we_m[i]) expect_eq("acc_wdata", acc_wdata[i], wdata_m[i]);
			end
		end
		if (rst_n && rst_h) begin
			assert (proc_reset == '0 || proc_reset == '1)
			else begin
				$display("FAIL %0t: proc_reset bits differ", $time);
				errors++;
			end
			if (last_shot_done) begin
				expect_eq("last_shot_done repeat", lsd_prev, 1'b0);
				expect_eq("shot_cnt at done", shot_cnt, nshot);
				pulse_cnt++;
			end
			if (!proc_reset[0] && pr_prev) begin
				fall_cnt++;
				// a later shot needs every elem_idle seen first
				if (shot_cnt != 0) expect_eq("idle before shot", idle_seen, 1'b1);
				done_seen = 1'b0;
			end
			if (!proc_reset[0] && &proc_done) done_seen = 1'b1;
			if (proc_reset[0] && !pr_prev) begin
				expect_eq("done before reset", done_seen, 1'b1);
				idle_seen = 1'b0;
			end
			if (proc_reset[0] && &elem_idle) idle_seen = 1'b1;
			if (shot_cnt != cnt_prev) cnt_steps.push_back(shot_cnt);
		end
		pr_prev = proc_reset[0];
		lsd_prev = last_shot_done;
		cnt_prev = shot_cnt;
		adc_h = adc;
		dac_h = dac;
		sel1_h = bb1_sel;
		sel2_h = bb2_sel;
		valid_h = acc_valid;
		data_h = acc_data;
		accrst_h = acc_reset;
		rst_h = rst_n;
	end

	initial begin
		int e;
		logic [3:0] sel_seen;
		logic [3:0] sel2_seen;
		rst_n = 1'b0;
		start = 1'b0;
		nshot = '0;
		proc_done = '0;
		elem_idle = '0;
		bb1_sel = '0;
		bb2_sel = '0;
		acc_valid = '0;
		acc_reset = 1'b0;
		for (int i = 0; i < 2; i++) adc[i] = '0;
		for (int i = 0; i < 4; i++) dac[i] = '0;
		for (int i = 0; i < NDLO; i++) acc_data[i] = '0;
		run_cycles(5);
		rst_n = 1'b1;

		// values after reset, held without start
		e = errors;
		for (int i = 0; i < 10; i++) begin
			@(negedge dspif);
			expect_eq("proc_reset idle", proc_reset, {NPROC{1'b1}});
			expect_eq("last_shot_done idle", last_shot_done, 1'b0);
			expect_eq("shot_cnt idle", shot_cnt, 0);
		end
		end_test("reset values", e);

		// three shots, then a fresh run of two
		e = errors;
		next_drive();
		fall_cnt = 0;
		pulse_cnt = 0;
		cnt_steps.delete();
		pulse_start(3);
		wait_last_shot(1000);
		run_cycles(3);
		expect_eq("low periods", fall_cnt, 3);
		expect_eq("done pulses", pulse_cnt, 1);
		expect_eq("count steps", cnt_steps.size(), 3);
		for (int i = 0; i < cnt_steps.size(); i++) expect_eq("count step", cnt_steps[i], i + 1);
		fall_cnt = 0;
		pulse_cnt = 0;
		cnt_steps.delete();
		pulse_start(2);
		wait_last_shot(1000);
		run_cycles(3);
		expect_eq("second run shots", fall_cnt, 2);
		expect_eq("second run pulses", pulse_cnt, 1);
		expect_eq("second run steps", cnt_steps.size(), 3);
		for (int i = 0; i < cnt_steps.size(); i++) expect_eq("restart step", cnt_steps[i], i);
		end_test("three shot run", e);
		end_test("core handshake order", e);

		// endless run, stopped by reset
		e = errors;
		pulse_cnt = 0;
		pulse_start(0);
		wait_shots_above(5, 2000);
		next_drive();
		expect_eq("endless pulses", pulse_cnt, 0);
		rst_n = 1'b0;
		run_cycles(5);
		rst_n = 1'b1;
		run_cycles(10);
		expect_eq("shot_cnt after reset", shot_cnt, 0);
		expect_eq("proc_reset after reset", proc_reset, {NPROC{1'b1}});
		expect_eq("pulses after reset", pulse_cnt, 0);
		end_test("endless run", e);

		// random converter data and selects
		e = errors;
		sel_seen = '0;
		sel2_seen = '0;
		for (int n = 0; n < 300; n++) begin
			for (int i = 0; i < 2; i++) adc[i] = sample_t'(take_bits(SAMPLE_W));
			for (int i = 0; i < 4; i++) begin
				for (int l = 0; l < DAC_LANES; l++) begin
					dac[i][l*SAMPLE_W +: SAMPLE_W] = sample_t'(take_bits(SAMPLE_W));
				end
			end
			bb1_sel = bb_sel_t'(take_bits(2));
			bb2_sel = bb_sel_t'(take_bits(2));
			sel_seen[bb1_sel] = 1'b1;
			sel2_seen[bb2_sel] = 1'b1;
			next_drive();
		end
		expect_eq("bb1 select coverage", sel_seen, 4'hf);
		expect_eq("bb2 select coverage", sel2_seen, 4'hf);
		end_test("baseband select", e);

		// random strobes until every address locks
		e = errors;
		for (int n = 0; n < 200; n++) begin
			acc_valid = NDLO'(take_bits(NDLO));
			for (int i = 0; i < NDLO; i++) acc_data[i] = {take_bits(32), take_bits(32)};
			next_drive();
		end
		acc_valid = '0;
		run_cycles(3);
		for (int i = 0; i < NDLO; i++) expect_eq("locked addr", acc_addr[i], 4'hf);
		acc_reset = 1'b1;
		next_drive();
		acc_reset = 1'b0;
		run_cycles(3);
		for (int i = 0; i < NDLO; i++) expect_eq("addr after clear", acc_addr[i], 0);
		end_test("accumulation writer", e);

		$display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
		if (errors == 0 && fail_cnt == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
